/* common/num_report_pkg.sv */
package num_report_pkg;

	// ALU operations, 3-bit encoding.
	typedef enum logic [2:0]
	{
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL
	} alu_op_e;

	// Operand and result width.
	localparam int DATA_W = 32;

	// Ten digits cover 4294967295.
	localparam int NUM_DIGITS = 10;
	localparam int BCD_W = 4 * NUM_DIGITS;

	localparam logic [7:0] ASCII_ZERO = 8'd48;

	// UART bit period in clock cycles, small for simulation.
	localparam int CLKS_PER_BIT = 8;
	localparam int CNT_W = (CLKS_PER_BIT > 2) ? $clog2(CLKS_PER_BIT) : 1;

endpackage

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu (
	input  logic                                clk,
	input  logic                                rst_n,
	input  logic                                start,
	input  logic [num_report_pkg::DATA_W-1:0]   operand_a,
	input  logic [num_report_pkg::DATA_W-1:0]   operand_b,
	input  num_report_pkg::alu_op_e             op,
	output logic [num_report_pkg::DATA_W-1:0]   result,
	output logic                                result_valid
);

	logic [num_report_pkg::DATA_W-1:0] alu_out;
	logic [4:0]                        shamt;

	// Shift amount comes from the low bits of operand b.
	assign shamt = operand_b[4:0];

	always_comb
	begin
		case (op)
			num_report_pkg::ALU_ADD: alu_out = operand_a + operand_b;
			num_report_pkg::ALU_SUB: alu_out = operand_a - operand_b;
			num_report_pkg::ALU_AND: alu_out = operand_a & operand_b;
			num_report_pkg::ALU_OR:  alu_out = operand_a | operand_b;
			num_report_pkg::ALU_XOR: alu_out = operand_a ^ operand_b;
			num_report_pkg::ALU_SLL: alu_out = operand_a << shamt;
			num_report_pkg::ALU_SRL: alu_out = operand_a >> shamt;
			default:                 alu_out = '0;
		endcase
	end

	// Result is held until the next start.
	always_ff @(posedge clk)
	begin
		if (start)
			result <= alu_out;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			result_valid <= 1'b0;
		else
			result_valid <= start;
	end

endmodule

/* hdl/bin_to_bcd.sv */
`timescale 1ns/1ps

module bin_to_bcd (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               result_valid,
	input  logic [num_report_pkg::DATA_W-1:0]  result,
	output logic [num_report_pkg::BCD_W-1:0]   bcd,
	output logic                               bcd_valid
);

	typedef enum logic [1:0]
	{
		IDLE,
		SHIFT,
		FINISH
	} state_e;

	typedef logic [$clog2(num_report_pkg::DATA_W)-1:0] bit_cnt_t;

	state_e                             state;
	bit_cnt_t                           bit_cnt;
	logic [num_report_pkg::DATA_W-1:0]  bin_sr;
	logic [num_report_pkg::BCD_W-1:0]   digits;
	logic [num_report_pkg::BCD_W-1:0]   digits_adj;

	// Add 3 to every digit of 5 or more before the shift.
	always_comb
	begin
		digits_adj = digits;
		for (int i = 0; i < num_report_pkg::NUM_DIGITS; i++)
		begin
			if (digits[4*i +: 4] >= 4'd5)
				digits_adj[4*i +: 4] = digits[4*i +: 4] + 4'd3;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state   <= IDLE;
			bit_cnt <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					bit_cnt <= '0;
					if (result_valid)
						state <= SHIFT;
				end
				SHIFT:
				begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == bit_cnt_t'(num_report_pkg::DATA_W - 1))
						state <= FINISH;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// One bit per cycle, MSB first.
	always_ff @(posedge clk)
	begin
		if (state == IDLE && result_valid)
		begin
			bin_sr <= result;
			digits <= '0;
		end
		else if (state == SHIFT)
		begin
			bin_sr <= {bin_sr[num_report_pkg::DATA_W-2:0], 1'b0};
			digits <= {digits_adj[num_report_pkg::BCD_W-2:0], bin_sr[num_report_pkg::DATA_W-1]};
		end
	end

	assign bcd       = digits;
	assign bcd_valid = (state == FINISH);

endmodule

/* hdl/digit_sender.sv */
`timescale 1ns/1ps

module digit_sender (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              bcd_valid,
	input  logic [num_report_pkg::BCD_W-1:0]  bcd,
	input  logic                              tx_busy,
	output logic [7:0]                        tx_data,
	output logic                              tx_start,
	output logic                              send_done
);

	typedef enum logic [1:0]
	{
		IDLE,
		ISSUE,
		WAIT_BUSY,
		WAIT_IDLE
	} state_e;

	typedef logic [$clog2(num_report_pkg::NUM_DIGITS + 1)-1:0] idx_t;

	state_e                            state;
	idx_t                              idx;
	logic [num_report_pkg::BCD_W-1:0]  digits_q;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= IDLE;
			idx   <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (bcd_valid)
					begin
						idx   <= idx_t'(num_report_pkg::NUM_DIGITS);
						state <= ISSUE;
					end
				end
				ISSUE:
				begin
					idx   <= idx - 1'b1;
					state <= WAIT_BUSY;
				end
				WAIT_BUSY:
				begin
					if (tx_busy)
						state <= WAIT_IDLE;
				end
				WAIT_IDLE:
				begin
					// Next character once the stop bit is out.
					if (!tx_busy)
						state <= (idx == '0) ? IDLE : ISSUE;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// Most significant digit sits on top and leaves first.
	always_ff @(posedge clk)
	begin
		if (state == IDLE && bcd_valid)
			digits_q <= bcd;
		else if (state == ISSUE)
			digits_q <= {digits_q[num_report_pkg::BCD_W-5:0], 4'd0};
	end

	assign tx_data   = num_report_pkg::ASCII_ZERO + {4'd0, digits_q[num_report_pkg::BCD_W-1 -: 4]};
	assign tx_start  = (state == ISSUE);
	assign send_done = (state == WAIT_IDLE) && !tx_busy && (idx == '0);

endmodule

/* hdl/num_report_top.sv */
`timescale 1ns/1ps

module num_report_top (
	input  logic                               clk,
	input  logic                               rst_n,
	input  logic                               start,
	input  logic [num_report_pkg::DATA_W-1:0]  operand_a,
	input  logic [num_report_pkg::DATA_W-1:0]  operand_b,
	input  num_report_pkg::alu_op_e            op,
	output logic                               tx,
	output logic                               busy,
	output logic                               report_done
);

	logic                              busy_q;
	logic                              start_ok;
	logic [num_report_pkg::DATA_W-1:0] result;
	logic                              result_valid;
	logic [num_report_pkg::BCD_W-1:0]  bcd;
	logic                              bcd_valid;
	logic [7:0]                        tx_data;
	logic                              tx_start;
	logic                              tx_busy;
	logic                              send_done;

	// Only one report in flight.
	assign start_ok = start && !busy;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			busy_q <= 1'b0;
		else if (start_ok)
			busy_q <= 1'b1;
		else if (send_done)
			busy_q <= 1'b0;
	end

	// Drops together with the done pulse.
	assign busy        = busy_q && !send_done;
	assign report_done = send_done;

	alu i_alu (
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start_ok),
		.operand_a    (operand_a),
		.operand_b    (operand_b),
		.op           (op),
		.result       (result),
		.result_valid (result_valid)
	);

	bin_to_bcd i_bin_to_bcd (
		.clk          (clk),
		.rst_n        (rst_n),
		.result_valid (result_valid),
		.result       (result),
		.bcd          (bcd),
		.bcd_valid    (bcd_valid)
	);

	digit_sender i_digit_sender (
		.clk       (clk),
		.rst_n     (rst_n),
		.bcd_valid (bcd_valid),
		.bcd       (bcd),
		.tx_busy   (tx_busy),
		.tx_data   (tx_data),
		.tx_start  (tx_start),
		.send_done (send_done)
	);

	uart_tx i_uart_tx (
		.clk      (clk),
		.rst_n    (rst_n),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.tx       (tx),
		.tx_busy  (tx_busy)
	);

endmodule

/* num_report.f */
common/num_report_pkg.sv
hdl/alu.sv
hdl/bin_to_bcd.sv
hdl/digit_sender.sv
uart_tx/uart_tx.sv
hdl/num_report_top.sv
test/tb_num_report.sv

/* test/tb_num_report.sv */
`timescale 1ns/1ps

module tb_num_report;

	localparam int CLK_PERIOD = 20;
	localparam int REPORT_CYCLES = num_report_pkg::NUM_DIGITS * (10 * num_report_pkg::CLKS_PER_BIT + 4)
		+ num_report_pkg::DATA_W + 10;
	localparam int NUM_REPORTS = 33;
	localparam int BIT_CLKS = num_report_pkg::CLKS_PER_BIT;

	logic                               clk;
	logic                               rst_n;
	logic                               start;
	logic [num_report_pkg::DATA_W-1:0]  operand_a;
	logic [num_report_pkg::DATA_W-1:0]  operand_b;
	num_report_pkg::alu_op_e            op;
	logic                               tx;
	logic                               busy;
	logic                               report_done;

	int          errors;
	int          done_cnt;
	int          rx_total;
	logic [7:0]  rx_q[$];

	num_report_top i_num_report_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.start       (start),
		.operand_a   (operand_a),
		.operand_b   (operand_b),
		.op          (op),
		.tx          (tx),
		.busy        (busy),
		.report_done (report_done)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
		input string msg);
		if (actual !== expected)
		begin
			$display("[FAIL] %0t: %s, got %0d, expected %0d", $time, msg, actual, expected);
			errors++;
		end
	endtask

	function automatic logic [31:0] expected_result(input logic [31:0] a, input logic [31:0] b,
		input num_report_pkg::alu_op_e o);
		case (o)
			num_report_pkg::ALU_ADD: return a + b;
			num_report_pkg::ALU_SUB: return a - b;
			num_report_pkg::ALU_AND: return a & b;
			num_report_pkg::ALU_OR:  return a | b;
			num_report_pkg::ALU_XOR: return a ^ b;
			num_report_pkg::ALU_SLL: return a << b[4:0];
			num_report_pkg::ALU_SRL: return a >> b[4:0];
			default:                 return '0;
		endcase
	endfunction

	// Position 0 is the most significant of the ten digits.
	function automatic logic [7:0] digit_char(input logic [31:0] value, input int pos);
		logic [63:0] scale;
		scale = 1;
		for (int k = 0; k < num_report_pkg::NUM_DIGITS - 1 - pos; k++)
			scale = scale * 10;
		return num_report_pkg::ASCII_ZERO + 8'((64'(value) / scale) % 10);
	endfunction

	// Samples each bit in its middle, counted from the falling start edge.
	task automatic receive_char(output logic [7:0] ch);
		@(negedge tx);
		repeat (BIT_CLKS / 2) @(negedge clk);
		if (tx !== 1'b0)
		begin
			$display("Error at %0t: start bit on tx did not stay low", $time);
			errors++;
		end
		for (int i = 0; i < 8; i++)
		begin
			repeat (BIT_CLKS) @(negedge clk);
			ch[i] = tx;
		end
		repeat (BIT_CLKS) @(negedge clk);
		if (tx !== 1'b1)
		begin
			$display("Error at %0t: missing stop bit on tx", $time);
			errors++;
		end
	endtask

	initial
	begin
		logic [7:0] ch;
		wait (rst_n === 1'b1);
		forever
		begin
			receive_char(ch);
			rx_q.push_back(ch);
			rx_total++;
		end
	end

	// All ten stop bits must be seen by the time report_done pulses.
	always @(negedge clk)
	begin
		if (rst_n && report_done === 1'b1)
		begin
			check_value(rx_total, 10 * (done_cnt + 1), "characters seen at report_done");
			check_value(busy, 0, "busy in report_done cycle");
			done_cnt++;
		end
	end

	task automatic start_report(input logic [31:0] a, input logic [31:0] b,
		input num_report_pkg::alu_op_e o);
		@(negedge clk);
		operand_a = a;
		operand_b = b;
		op = o;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic wait_report_done();
		int cycles;
		cycles = 0;
		while (report_done !== 1'b1 && cycles < 2 * REPORT_CYCLES)
		begin
			check_value(busy, 1, "busy while report runs");
			@(negedge clk);
			cycles++;
		end
		if (report_done !== 1'b1)
		begin
			$display("Error at %0t: report_done never came after start", $time);
			errors++;
		end
	endtask

	task automatic check_chars(input logic [31:0] value);
		logic [7:0] ch;
		for (int i = 0; i < num_report_pkg::NUM_DIGITS; i++)
		begin
			if (rx_q.size() == 0)
			begin
				$display("Error at %0t: character %0d of %0d never arrived", $time, i, value);
				errors++;
			end
			else
			begin
				ch = rx_q.pop_front();
				check_value(ch, digit_char(value, i), $sformatf("digit %0d of %0d", i, value));
			end
		end
	endtask

	task automatic run_report(input logic [31:0] a, input logic [31:0] b,
		input num_report_pkg::alu_op_e o);
		start_report(a, b, o);
		wait_report_done();
		check_chars(expected_result(a, b, o));
	endtask

	task automatic test_idle_after_reset();
		check_value(tx, 1, "tx after reset");
		check_value(busy, 0, "busy after reset");
		repeat (50)
		begin
			@(negedge clk);
			check_value(tx, 1, "tx idle without start");
			check_value(report_done, 0, "report_done without start");
		end
	endtask

	task automatic test_each_opcode();
		run_report(32'd1234567890, 32'd987654321, num_report_pkg::ALU_ADD);
		run_report(32'hffff_fffe, 32'd1, num_report_pkg::ALU_ADD);
		run_report(32'd5, 32'd7, num_report_pkg::ALU_SUB);
		run_report(32'd100, 32'd100, num_report_pkg::ALU_SUB);
		run_report(32'hdead_beef, 32'h0ff0_f0f0, num_report_pkg::ALU_AND);
		run_report(32'h1200_0034, 32'h0056_7800, num_report_pkg::ALU_OR);
		run_report(32'ha5a5_a5a5, 32'h0f0f_0f0f, num_report_pkg::ALU_XOR);
		run_report(32'd1, 32'd31, num_report_pkg::ALU_SLL);
		run_report(32'hffff_ffff, 32'h0000_0024, num_report_pkg::ALU_SRL);
	endtask

	task automatic test_random_reports();
		logic [31:0]             a;
		logic [31:0]             b;
		num_report_pkg::alu_op_e o;
		for (int n = 0; n < 20; n++)
		begin
			a = $urandom;
			b = $urandom;
			o = num_report_pkg::alu_op_e'($urandom % 7);
			run_report(a, b, o);
		end
	endtask

	task automatic test_start_while_busy();
		int done_before;
		start_report(32'd4000000000, 32'd1, num_report_pkg::ALU_ADD);
		// The previous report's done pulse has been counted by now.
		done_before = done_cnt;
		repeat (5) @(negedge clk);
		operand_a = 32'd7;
		operand_b = 32'd8;
		op = num_report_pkg::ALU_OR;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		wait_report_done();
		check_chars(32'd4000000001);
		repeat (200)
		begin
			@(negedge clk);
			check_value(tx, 1, "tx quiet after ignored start");
		end
		check_value(rx_q.size(), 0, "extra characters after ignored start");
		check_value(done_cnt - done_before, 1, "reports after ignored start");
	endtask

	task automatic test_busy_and_done();
		int done_before;
		done_before = done_cnt;
		run_report(32'd42, 32'd3, num_report_pkg::ALU_SLL);
		repeat (20)
		begin
			@(negedge clk);
			check_value(busy, 0, "busy after report_done");
		end
		check_value(done_cnt - done_before, 1, "report_done pulses per report");
	endtask

	task automatic test_back_to_back();
		start_report(32'd99999, 32'd1, num_report_pkg::ALU_ADD);
		wait_report_done();
		start_report(32'd3, 32'd10, num_report_pkg::ALU_SUB);
		wait_report_done();
		check_chars(32'd100000);
		check_chars(32'hffff_fff9);
	endtask

	initial
	begin
		#(NUM_REPORTS * REPORT_CYCLES * 2 * CLK_PERIOD);
		$display("Timeout: the run did not finish in time, %0d errors so far", errors);
		$display("FAIL: see errors above");
		$finish;
	end

	initial
	begin
		void'($urandom(32'hf6b5));
		clk = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		operand_a = '0;
		operand_b = '0;
		op = num_report_pkg::ALU_ADD;
		errors = 0;
		done_cnt = 0;
		rx_total = 0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;

		test_idle_after_reset();
		test_each_opcode();
		test_random_reports();
		test_start_while_busy();
		test_busy_and_done();
		test_back_to_back();

		$display("Errors: %0d, reports completed: %0d", errors, done_cnt);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* uart_tx/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        tx_start,
	input  logic [7:0]  tx_data,
	output logic        tx,
	output logic        tx_busy
);

	typedef logic [num_report_pkg::CNT_W-1:0] clk_cnt_t;

	logic [9:0]  frame;
	clk_cnt_t    clk_cnt;
	logic [3:0]  bit_cnt;
	logic        bit_end;

	assign bit_end = (clk_cnt == clk_cnt_t'(num_report_pkg::CLKS_PER_BIT - 1));

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			frame   <= '1;
			clk_cnt <= '0;
			bit_cnt <= '0;
			tx_busy <= 1'b0;
		end
		else if (!tx_busy)
		begin
			clk_cnt <= '0;
			bit_cnt <= '0;
			if (tx_start)
			begin
				// Stop bit, data LSB first, start bit at the bottom.
				frame   <= {1'b1, tx_data, 1'b0};
				tx_busy <= 1'b1;
			end
		end
		else if (bit_end)
		begin
			clk_cnt <= '0;
			frame   <= {1'b1, frame[9:1]};
			if (bit_cnt == 4'd9)
				tx_busy <= 1'b0;
			else
				bit_cnt <= bit_cnt + 1'b1;
		end
		else
		begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	// Line idles high since the frame refills with ones.
	assign tx = frame[0];

endmodule
